//--- source/i8008_config.svh
`ifndef I8008_CONFIG_SVH
`define I8008_CONFIG_SVH

// Data port and internal bus width
`define I8008_DATA_W 8

// Program address width, high byte uses only bits 5:0
`define I8008_ADDR_W 14

// Scratchpad registers A, B, C, D, E, H, L
`define I8008_NUM_REGS 7

`endif

//--- source/i8008_pkg.sv
`default_nettype none

package i8008_pkg;

  // Encoded as on the S2:S0 state pins of the original part
  typedef enum logic [2:0] {
    WAIT    = 3'b000,
    T3      = 3'b001,
    T1      = 3'b010,
    STOPPED = 3'b011,
    T2      = 3'b100,
    T5      = 3'b101,
    T4      = 3'b111
  } t_state_t;

  typedef enum logic [1:0] {
    CYCLE1 = 2'b00,  // Instruction fetch
    CYCLE2 = 2'b01,
    CYCLE3 = 2'b10
  } cycle_t;

  // Sent on d_out[7:6] during T2
  typedef enum logic [1:0] {
    PCI = 2'b00,
    PCR = 2'b10,
    PCW = 2'b11
  } cycle_type_t;

  // Same order as the PPP field of the ALU opcodes
  typedef enum logic [2:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_AND, ALU_XOR, ALU_OR, ALU_CMP
  } alu_op_t;

  typedef enum logic [2:0] {
    REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_M
  } reg_sel_t;

  typedef enum logic [3:0] {
    OP_LRR, OP_LRI, OP_LRM, OP_LMR, OP_LMI,
    OP_ALUR, OP_ALUI, OP_ALUM,
    OP_INR, OP_DCR,
    OP_JMP, OP_JTC, OP_JFC,
    OP_HLT, OP_ILLEGAL
  } opcode_t;

  typedef enum logic [2:0] {
    BUS_NONE, BUS_PC_LO, BUS_PC_HI, BUS_RF, BUS_ALU, BUS_TMP_A, BUS_TMP_B, BUS_DIN
  } bus_src_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity;  // Set on even parity
  } flags_t;

endpackage

`default_nettype wire

//--- source/ctrl_if.sv
`default_nettype none

// Control strobes from the sequencer to the datapath units
interface ctrl_if;
  import i8008_pkg::*;

  bus_src_t    bus_src;
  logic        rf_we;
  reg_sel_t    rf_sel;
  logic        tmp_a_we;
  logic        tmp_b_we;
  logic        ir_we;
  alu_op_t     alu_op;
  logic        alu_incdec;  // INr/DCr instead of alu_op
  logic        alu_dec;
  logic        flags_we;
  logic        pc_inc;
  logic        pc_load_lo;
  logic        pc_load_hi;
  cycle_type_t cycle_type;
  logic        d_out_en;    // Bus goes out on d_out
  logic        addr_hi;     // T2, cycle type replaces bits 7:6

  modport sequencer (
    output bus_src, rf_we, rf_sel, tmp_a_we, tmp_b_we, ir_we, alu_op, alu_incdec,
           alu_dec, flags_we, pc_inc, pc_load_lo, pc_load_hi, cycle_type,
           d_out_en, addr_hi
  );
  modport datapath (input bus_src, tmp_a_we, tmp_b_we, ir_we, cycle_type, d_out_en, addr_hi);
  modport reg_file (input rf_we, rf_sel);
  modport alu (input alu_op, alu_incdec, alu_dec, flags_we);
  modport pc (input pc_inc, pc_load_lo, pc_load_hi);

endinterface

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none
`include "i8008_config.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     rst,
  ctrl_if.reg_file                 ctrl,
  input  logic [`I8008_DATA_W-1:0] bus,
  output logic [`I8008_DATA_W-1:0] rf_out
);
  import i8008_pkg::*;

  logic [`I8008_DATA_W-1:0] regs [`I8008_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `I8008_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (ctrl.rf_we && ctrl.rf_sel != REG_M) begin
      regs[ctrl.rf_sel] <= bus;
    end
  end

  // M is not a register here, reads as zero
  assign rf_out = (ctrl.rf_sel == REG_M) ? '0 : regs[ctrl.rf_sel];

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none
`include "i8008_config.svh"

module alu (
  input  logic                     clk,
  input  logic                     rst,
  ctrl_if.alu                      ctrl,
  input  logic [`I8008_DATA_W-1:0] tmp_a,
  input  logic [`I8008_DATA_W-1:0] tmp_b,
  output logic [`I8008_DATA_W-1:0] alu_out,
  output i8008_pkg::flags_t        flags
);
  import i8008_pkg::*;

  localparam int W = `I8008_DATA_W;

  logic [W:0]   a_ext, b_ext, cy_ext;
  logic [W:0]   wide;  // Top bit is carry or borrow
  logic [W-1:0] result;
  flags_t       flags_d;

  assign a_ext  = {1'b0, tmp_a};
  assign b_ext  = {1'b0, tmp_b};
  assign cy_ext = {{W{1'b0}}, flags.carry};

  always_comb begin
    if (ctrl.alu_incdec) begin
      wide = ctrl.alu_dec ? a_ext - (W + 1)'(1) : a_ext + (W + 1)'(1);
    end else begin
      case (ctrl.alu_op)
        ALU_ADD: wide = a_ext + b_ext;
        ALU_ADC: wide = a_ext + b_ext + cy_ext;
        ALU_SUB: wide = a_ext - b_ext;
        ALU_SBB: wide = a_ext - b_ext - cy_ext;
        ALU_AND: wide = {1'b0, tmp_a & tmp_b};
        ALU_XOR: wide = {1'b0, tmp_a ^ tmp_b};
        ALU_OR:  wide = {1'b0, tmp_a | tmp_b};
        default: wide = a_ext - b_ext;  // CMP, result only feeds flags
      endcase
    end
    result = wide[W-1:0];

    flags_d.carry  = ctrl.alu_incdec ? flags.carry : wide[W];
    flags_d.zero   = (result == '0);
    flags_d.sign   = result[W-1];
    flags_d.parity = ~^result;
  end

  assign alu_out = result;

  always_ff @(posedge clk) begin
    if (rst)
      flags <= '0;
    else if (ctrl.flags_we)
      flags <= flags_d;
  end

endmodule

`default_nettype wire

//--- source/program_counter.sv
`default_nettype none
`include "i8008_config.svh"

module program_counter (
  input  logic                     clk,
  input  logic                     rst,
  ctrl_if.pc                       ctrl,
  input  logic [`I8008_DATA_W-1:0] bus,
  output logic [`I8008_ADDR_W-1:0] pc
);

  localparam int W  = `I8008_DATA_W;
  localparam int AW = `I8008_ADDR_W;

  // Jump target arrives one byte at a time with the low byte first
  always_ff @(posedge clk) begin
    if (rst)
      pc <= '0;
    else if (ctrl.pc_load_lo)
      pc[W-1:0] <= bus;
    else if (ctrl.pc_load_hi)
      pc[AW-1:W] <= bus[AW-W-1:0];  // Bits 7:6 of the byte are dropped
    else if (ctrl.pc_inc)
      pc <= pc + AW'(1);
  end

endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none
`include "i8008_config.svh"

module datapath (
  input  logic                     clk,
  input  logic                     rst,
  ctrl_if.datapath                 ctrl,
  input  logic [`I8008_DATA_W-1:0] d_in,
  input  logic [`I8008_DATA_W-1:0] rf_out,
  input  logic [`I8008_DATA_W-1:0] alu_out,
  input  logic [`I8008_ADDR_W-1:0] pc,
  output logic [`I8008_DATA_W-1:0] bus,
  output logic [`I8008_DATA_W-1:0] d_out,
  output logic [`I8008_DATA_W-1:0] instr,
  output logic [`I8008_DATA_W-1:0] tmp_a,
  output logic [`I8008_DATA_W-1:0] tmp_b
);
  import i8008_pkg::*;

  localparam int W  = `I8008_DATA_W;
  localparam int AW = `I8008_ADDR_W;

  logic [W-1:0] ir;

  always_ff @(posedge clk) begin
    if (rst)
      ir <= '0;
    else if (ctrl.ir_we)
      ir <= d_in;
  end

  // Fetched byte is visible to decode during its own T3
  assign instr = ctrl.ir_we ? d_in : ir;

  always_ff @(posedge clk) begin
    if (ctrl.tmp_a_we)
      tmp_a <= bus;
    if (ctrl.tmp_b_we)
      tmp_b <= bus;
  end

  always_comb begin
    case (ctrl.bus_src)
      BUS_PC_LO: bus = pc[W-1:0];
      BUS_PC_HI: bus = {{(2 * W - AW){1'b0}}, pc[AW-1:W]};
      BUS_RF:    bus = rf_out;
      BUS_ALU:   bus = alu_out;
      BUS_TMP_A: bus = tmp_a;
      BUS_TMP_B: bus = tmp_b;
      BUS_DIN:   bus = d_in;
      default:   bus = '0;
    endcase
  end

  // Zero whenever sync is low
  always_comb begin
    if (!ctrl.d_out_en)
      d_out = '0;
    else if (ctrl.addr_hi)
      d_out = {ctrl.cycle_type, bus[W-3:0]};
    else
      d_out = bus;
  end

endmodule

`default_nettype wire

//--- source/sequencer.sv
`default_nettype none
`include "i8008_config.svh"

module sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ready,
  input  logic [`I8008_DATA_W-1:0] instr,
  input  i8008_pkg::flags_t        flags,
  ctrl_if.sequencer                ctrl,
  output i8008_pkg::t_state_t      state,
  output logic                     sync
);
  import i8008_pkg::*;

  t_state_t state_d;
  cycle_t   cycle, cycle_d;
  opcode_t  op;
  reg_sel_t ddd, sss;
  alu_op_t  op_sel;
  logic     cond, take;
  logic     mem_cycle, write_cycle;

  assign ddd    = reg_sel_t'(instr[5:3]);
  assign sss    = reg_sel_t'(instr[2:0]);
  assign op_sel = alu_op_t'(instr[5:3]);

  always_comb begin
    op = OP_ILLEGAL;  // Rotates, stack and I/O land here
    case (instr[7:6])
      2'b00: begin
        if (instr[5:1] == 5'b00000)
          op = OP_HLT;
        else if (instr[2:1] == 2'b00 && ddd != REG_M)
          op = instr[0] ? OP_DCR : OP_INR;
        else if (instr[2:0] == 3'b100)
          op = OP_ALUI;
        else if (instr[2:0] == 3'b110)
          op = (ddd == REG_M) ? OP_LMI : OP_LRI;
      end
      2'b01: begin
        if (instr[2:0] == 3'b100)
          op = OP_JMP;
        else if (instr[2:0] == 3'b000)
          op = instr[5] ? OP_JTC : OP_JFC;
      end
      2'b10: op = (sss == REG_M) ? OP_ALUM : OP_ALUR;
      default: begin
        if (instr == 8'hff)
          op = OP_HLT;
        else if (sss == REG_M)
          op = OP_LRM;
        else if (ddd == REG_M)
          op = OP_LMR;
        else
          op = OP_LRR;
      end
    endcase
  end

  // Jump condition from bits 4:3
  always_comb begin
    case (instr[4:3])
      2'b00:   cond = flags.carry;
      2'b01:   cond = flags.zero;
      2'b10:   cond = flags.sign;
      default: cond = flags.parity;
    endcase
    take = (op == OP_JMP) || (op == OP_JTC && cond) || (op == OP_JFC && !cond);
  end

  // Cycles addressed by H:L instead of the PC
  assign mem_cycle = (cycle == CYCLE2 && op inside {OP_LRM, OP_LMR, OP_ALUM}) ||
                     (cycle == CYCLE3 && op == OP_LMI);
  assign write_cycle = (cycle == CYCLE2 && op == OP_LMR) ||
                       (cycle == CYCLE3 && op == OP_LMI);

  assign ctrl.cycle_type = (cycle == CYCLE1) ? PCI : (write_cycle ? PCW : PCR);
  assign sync = (state == T1) || (state == T2) || (state == T3 && write_cycle);
  assign ctrl.d_out_en = sync;
  assign ctrl.addr_hi  = (state == T2);
  assign ctrl.ir_we    = (cycle == CYCLE1) && (state == T3);
  assign ctrl.pc_inc   = (state == T2) && !mem_cycle;

  always_comb begin
    state_d         = state;
    cycle_d         = cycle;
    ctrl.bus_src    = BUS_NONE;
    ctrl.rf_we      = 1'b0;
    ctrl.rf_sel     = REG_A;
    ctrl.tmp_a_we   = 1'b0;
    ctrl.tmp_b_we   = 1'b0;
    ctrl.alu_op     = op_sel;
    ctrl.alu_incdec = 1'b0;
    ctrl.alu_dec    = 1'b0;
    ctrl.flags_we   = 1'b0;
    ctrl.pc_load_lo = 1'b0;
    ctrl.pc_load_hi = 1'b0;

    case (state)
      T1: begin
        ctrl.bus_src = mem_cycle ? BUS_RF : BUS_PC_LO;
        ctrl.rf_sel  = REG_L;
        state_d      = T2;
      end
      T2: begin
        ctrl.bus_src = mem_cycle ? BUS_RF : BUS_PC_HI;
        ctrl.rf_sel  = REG_H;
        state_d      = ready ? T3 : WAIT;
      end
      WAIT: state_d = ready ? T3 : WAIT;
      T3: begin
        state_d = T1;
        cycle_d = CYCLE1;
        if (cycle == CYCLE1) begin
          // IR takes d_in directly, bus is free to copy A for the ALU
          ctrl.bus_src  = BUS_RF;
          ctrl.tmp_a_we = 1'b1;
          if (op == OP_HLT)
            state_d = STOPPED;
          else if (op inside {OP_LRR, OP_ALUR, OP_INR, OP_DCR})
            state_d = T4;
          else if (op != OP_ILLEGAL)
            cycle_d = CYCLE2;
        end else if (write_cycle) begin
          ctrl.bus_src = (op == OP_LMR) ? BUS_RF : BUS_TMP_B;
          ctrl.rf_sel  = sss;
        end else begin
          ctrl.bus_src = BUS_DIN;
          if (cycle == CYCLE3) begin
            ctrl.tmp_a_we = 1'b1;  // Jump high address
            if (take) begin
              state_d = T4;
              cycle_d = CYCLE3;
            end
          end else begin
            ctrl.tmp_b_we = 1'b1;
            if (op inside {OP_LMI, OP_JMP, OP_JTC, OP_JFC})
              cycle_d = CYCLE3;
            else begin
              state_d = T4;
              cycle_d = CYCLE2;
            end
          end
        end
      end
      T4: begin
        state_d = T5;
        if (cycle == CYCLE3) begin
          ctrl.bus_src    = BUS_TMP_B;
          ctrl.pc_load_lo = 1'b1;
        end else if (cycle == CYCLE1) begin
          ctrl.bus_src = BUS_RF;
          if (op inside {OP_INR, OP_DCR}) begin
            ctrl.rf_sel   = ddd;
            ctrl.tmp_a_we = 1'b1;
          end else begin
            ctrl.rf_sel   = sss;
            ctrl.tmp_b_we = 1'b1;
          end
        end
      end
      T5: begin
        state_d = T1;
        cycle_d = CYCLE1;
        case (op)
          OP_LRR, OP_LRI, OP_LRM: begin
            ctrl.bus_src = BUS_TMP_B;
            ctrl.rf_sel  = ddd;
            ctrl.rf_we   = 1'b1;
          end
          OP_ALUR, OP_ALUI, OP_ALUM: begin
            ctrl.bus_src  = BUS_ALU;
            ctrl.rf_we    = (op_sel != ALU_CMP);  // CMP keeps A
            ctrl.flags_we = 1'b1;
          end
          OP_INR, OP_DCR: begin
            ctrl.bus_src    = BUS_ALU;
            ctrl.alu_incdec = 1'b1;
            ctrl.alu_dec    = instr[0];
            ctrl.rf_sel     = ddd;
            ctrl.rf_we      = 1'b1;
            ctrl.flags_we   = 1'b1;
          end
          OP_JMP, OP_JTC, OP_JFC: begin
            ctrl.bus_src    = BUS_TMP_A;
            ctrl.pc_load_hi = 1'b1;
          end
          default: ;
        endcase
      end
      STOPPED: state_d = STOPPED;  // Left only through reset
      default: begin
        state_d = T1;
        cycle_d = CYCLE1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
    end else begin
      state <= state_d;
      cycle <= cycle_d;
    end
  end

endmodule

`default_nettype wire

//--- source/i8008_core.sv
`default_nettype none
`include "i8008_config.svh"

module i8008_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ready,
  input  logic [`I8008_DATA_W-1:0] d_in,
  output logic [`I8008_DATA_W-1:0] d_out,
  output logic                     sync,
  output i8008_pkg::t_state_t      state
);
  import i8008_pkg::*;

  logic [`I8008_DATA_W-1:0] bus;
  logic [`I8008_DATA_W-1:0] instr;
  logic [`I8008_DATA_W-1:0] rf_out;
  logic [`I8008_DATA_W-1:0] alu_out;
  logic [`I8008_DATA_W-1:0] tmp_a;
  logic [`I8008_DATA_W-1:0] tmp_b;
  logic [`I8008_ADDR_W-1:0] pc;
  flags_t                   flags;

  ctrl_if ctrl ();

  sequencer sequencer_i (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .instr (instr),
    .flags (flags),
    .ctrl  (ctrl.sequencer),
    .state (state),
    .sync  (sync)
  );

  datapath datapath_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl.datapath),
    .d_in    (d_in),
    .rf_out  (rf_out),
    .alu_out (alu_out),
    .pc      (pc),
    .bus     (bus),
    .d_out   (d_out),
    .instr   (instr),
    .tmp_a   (tmp_a),
    .tmp_b   (tmp_b)
  );

  reg_file reg_file_i (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl.reg_file),
    .bus    (bus),
    .rf_out (rf_out)
  );

  alu alu_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl.alu),
    .tmp_a   (tmp_a),
    .tmp_b   (tmp_b),
    .alu_out (alu_out),
    .flags   (flags)
  );

  program_counter program_counter_i (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl.pc),
    .bus  (bus),
    .pc   (pc)
  );

endmodule

`default_nettype wire

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
  end
endtask

task automatic check_addr(input string name, input logic [13:0] got, input logic [13:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %04h expected %04h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic check_state(input string name, input t_state_t got, input t_state_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %s expected %s", $time, name, got.name(),
             exp.name());
  end
endtask

task automatic check_ctype(input string name, input cycle_type_t got, input cycle_type_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %s expected %s", $time, name, got.name(),
             exp.name());
  end
endtask

// Fill depends on all 14 address bits
task automatic clear_program();
  for (int i = 0; i < (1 << `I8008_ADDR_W); i++)
    mem[14'(i)] = 8'(i) ^ 8'(i >> 6);
  prog_ptr = 0;
  exp_addr.delete();
  exp_data.delete();
endtask

task automatic emit(input logic [7:0] b);
  mem[14'(prog_ptr)] = b;
  prog_ptr++;
endtask

// Jump target, low byte then high byte
task automatic put_addr(input logic [13:0] a);
  emit(a[7:0]);
  emit({2'b00, a[13:8]});
endtask

task automatic expect_write(input logic [13:0] a, input logic [7:0] d);
  exp_addr.push_back(a);
  exp_data.push_back(d);
endtask

task automatic compare_writes(input string test_name);
  if (wr_data.size() != exp_data.size()) begin
    errors++;
    $display("ERROR at %0t: %s recorded %0d memory writes, expected %0d", $time, test_name,
             wr_data.size(), exp_data.size());
  end else begin
    for (int i = 0; i < exp_data.size(); i++) begin
      check_addr("write address", wr_addr[i], exp_addr[i]);
      check_byte("write data", wr_data[i], exp_data[i]);
    end
  end
endtask

`endif

//--- tests/tb_i8008.sv
`default_nettype none
`include "i8008_config.svh"

module tb_i8008;
  import i8008_pkg::*;

  localparam logic [13:0] HL_ADDR = 14'h2000;

  logic                     clk;
  logic                     rst = 1'b1;
  logic                     ready = 1'b1;
  logic [`I8008_DATA_W-1:0] d_in = 8'h00;
  logic [`I8008_DATA_W-1:0] d_out;
  logic                     sync;
  t_state_t                 state;

  logic [7:0]  mem [1 << `I8008_ADDR_W];
  logic [7:0]  overlay [logic [13:0]];  // Bytes written by the core
  logic [13:0] wr_addr [$];
  logic [7:0]  wr_data [$];
  logic [13:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  logic [13:0] fetch_q [$];
  cycle_type_t ctype_q [$];
  int          errors;
  int          checks;
  int          wait_errors;
  int          sync_count;
  int          prog_ptr;
  logic [31:0] lfsr = 32'd71634;
  bit          rand_ready;

  logic [7:0]  addr_lo;
  logic [13:0] cur_addr;
  cycle_type_t cur_type;
  t_state_t    last_state;

  // Reference model of A, B, the byte at H:L and flags
  logic [7:0] m_a;
  logic [7:0] m_b;
  logic [7:0] m_m;
  logic       m_cy;
  logic       m_z;
  logic       m_s;
  logic       m_p;

  `include "tb_checks.svh"

  i8008_core i8008_core_i (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .d_in  (d_in),
    .d_out (d_out),
    .sync  (sync),
    .state (state)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic next_rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'hA300_0000;
    return b;
  endfunction

  // Memory model answers bus cycles on the falling edge
  always @(negedge clk) begin
    if (state == WAIT && ready) begin
      wait_errors++;
      $display("ERROR at %0t: WAIT entered although ready was high", $time);
    end
    if (state == T3 && last_state inside {T2, WAIT} && !ready) begin
      wait_errors++;
      $display("ERROR at %0t: T3 entered although ready was low", $time);
    end
    if (sync)
      sync_count++;
    case (state)
      T1: addr_lo = d_out;
      T2: begin
        cur_type = cycle_type_t'(d_out[7:6]);
        cur_addr = {d_out[5:0], addr_lo};
        ctype_q.push_back(cur_type);
        if (cur_type == PCI)
          fetch_q.push_back(cur_addr);
      end
      T3: begin
        if (cur_type == PCW) begin
          wr_addr.push_back(cur_addr);
          wr_data.push_back(d_out);
          overlay[cur_addr] = d_out;
        end else begin
          d_in = overlay.exists(cur_addr) ? overlay[cur_addr] : mem[cur_addr];
        end
      end
      default: ;
    endcase
    last_state = state;
    ready = rand_ready ? next_rand_bit() : 1'b1;
  end

  task automatic run_program(input bit rnd);
    int cycles;
    int sync_at_stop;
    int writes_at_stop;
    rst = 1'b1;
    rand_ready = rnd;
    wr_addr.delete();
    wr_data.delete();
    fetch_q.delete();
    ctype_q.delete();
    overlay.delete();
    sync_count = 0;
    repeat (8) @(negedge clk);
    check_state("state", state, T1);
    check_bit("sync", sync, 1'b1);
    check_byte("d_out", d_out, 8'h00);
    rst = 1'b0;
    cycles = 0;
    while (state != STOPPED && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (state != STOPPED) begin
      errors++;
      $display("ERROR at %0t: core did not reach STOPPED in %0d cycles", $time, cycles);
    end
    sync_at_stop = sync_count;
    writes_at_stop = wr_data.size();
    repeat (200) @(negedge clk);  // Idle window after HLT
    check_state("state", state, STOPPED);
    if (sync_count != sync_at_stop || wr_data.size() != writes_at_stop) begin
      errors++;
      $display("ERROR at %0t: bus activity seen after the core stopped", $time);
    end
  endtask

  task automatic set_flags(input logic [7:0] r);
    m_z = (r == 8'h00);
    m_s = r[7];
    m_p = ~^r;  // Even parity
  endtask

  task automatic model_alu(input alu_op_t op, input logic [7:0] y);
    logic [8:0] w;
    case (op)
      ALU_ADD: w = {1'b0, m_a} + {1'b0, y};
      ALU_ADC: w = {1'b0, m_a} + {1'b0, y} + {8'h00, m_cy};
      ALU_SBB: w = {1'b0, m_a} - {1'b0, y} - {8'h00, m_cy};
      ALU_AND: w = {1'b0, m_a & y};
      ALU_XOR: w = {1'b0, m_a ^ y};
      ALU_OR:  w = {1'b0, m_a | y};
      default: w = {1'b0, m_a} - {1'b0, y};  // SUB and CMP
    endcase
    m_cy = w[8];
    set_flags(w[7:0]);
    if (op != ALU_CMP)
      m_a = w[7:0];
  endtask

  task automatic reset_model();
    m_a = 8'h00;
    m_b = 8'h00;
    m_m = 8'h77;
    m_cy = 1'b0;
    set_flags(8'h00);
    mem[HL_ADDR] = m_m;
    emit(8'h2E);  // H = 20
    emit(8'h20);
    emit(8'h36);  // L = 00
    emit(8'h00);
  endtask

  task automatic load_a(input logic [7:0] v);
    emit(8'h06);
    emit(v);
    m_a = v;
  endtask

  task automatic load_b(input logic [7:0] v);
    emit(8'h0E);
    emit(v);
    m_b = v;
  endtask

  task automatic alu_reg(input alu_op_t op);
    emit({2'b10, op, 3'b001});  // Operand B
    model_alu(op, m_b);
  endtask

  task automatic alu_imm(input alu_op_t op, input logic [7:0] v);
    emit({2'b00, op, 3'b100});
    emit(v);
    model_alu(op, v);
  endtask

  task automatic alu_mem(input alu_op_t op);
    emit({2'b10, op, 3'b111});
    model_alu(op, m_m);
  endtask

  task automatic incdec_b(input logic dec);
    emit({7'b0000100, dec});
    m_b = dec ? m_b - 8'd1 : m_b + 8'd1;
    set_flags(m_b);  // Carry kept
  endtask

  task automatic store_a();
    emit(8'hF8);
    m_m = m_a;
    expect_write(HL_ADDR, m_a);
  endtask

  task automatic store_b();
    emit(8'hF9);
    m_m = m_b;
    expect_write(HL_ADDR, m_b);
  endtask

  task automatic test_reset_fetch();
    clear_program();
    emit(8'hC8);  // LBA
    emit(8'hD1);  // LCB
    emit(8'hE2);  // LEC
    emit(8'hFF);
    run_program(1'b0);
    if (fetch_q.size() < 4) begin
      errors++;
      $display("ERROR at %0t: only %0d fetch cycles seen", $time, fetch_q.size());
    end else begin
      check_ctype("first cycle type", ctype_q[0], PCI);
      for (int i = 0; i < 4; i++)
        check_addr("fetch address", fetch_q[i], 14'(i));
    end
  endtask

  task automatic test_load_store();
    clear_program();
    emit(8'h2E);
    emit(8'h12);
    emit(8'h36);
    emit(8'h34);
    emit(8'h0E);  // B = A5
    emit(8'hA5);
    emit(8'hD1);  // C = B
    emit(8'hFA);  // M = C
    emit(8'h3E);  // M = 5C
    emit(8'h5C);
    emit(8'h36);
    emit(8'h35);
    emit(8'hF9);  // M = B
    emit(8'hFF);
    expect_write(14'h1234, 8'hA5);
    expect_write(14'h1234, 8'h5C);
    expect_write(14'h1235, 8'hA5);
    run_program(1'b0);
    compare_writes("load/store");
  endtask

  task automatic test_alu(input bit rnd);
    clear_program();
    reset_model();
    load_a(8'hF0);
    load_b(8'h30);
    alu_reg(ALU_ADD);
    store_a();
    alu_imm(ALU_ADC, 8'h05);
    store_a();
    load_a(8'h10);
    alu_imm(ALU_ADD, 8'hF8);
    alu_reg(ALU_SBB);
    store_a();
    alu_mem(ALU_SUB);
    store_a();
    emit(8'hCF);  // B = M
    m_b = m_m;
    incdec_b(1'b0);
    incdec_b(1'b1);
    incdec_b(1'b1);
    store_b();
    load_a(8'h5A);
    alu_imm(ALU_AND, 8'h0F);
    alu_mem(ALU_XOR);
    alu_reg(ALU_OR);
    store_a();
    alu_imm(ALU_CMP, 8'h3C);
    alu_imm(ALU_ADC, 8'h00);
    store_a();
    load_a(8'h00);
    alu_imm(ALU_SUB, 8'h01);
    alu_mem(ALU_SBB);
    store_a();
    emit(8'hFF);
    run_program(rnd);
    compare_writes(rnd ? "alu with wait states" : "alu");
  endtask

  task automatic test_jumps();
    logic [7:0]  xs [4];
    logic [7:0]  ys [4];
    logic [1:0]  ccv;
    logic        sense;
    logic        cond;
    logic [13:0] j;
    logic [6:0]  idx;
    xs = '{8'hF0, 8'h01, 8'h80, 8'h40};
    ys = '{8'h20, 8'h02, 8'h80, 8'h40};
    clear_program();
    reset_model();
    for (int s = 0; s < 4; s++) begin
      for (int cc = 0; cc < 4; cc++) begin
        for (int t = 0; t < 2; t++) begin
          ccv = 2'(cc);
          sense = 1'(t);
          idx = 7'(s * 8 + cc * 2 + t);
          load_a(xs[s]);
          alu_imm(ALU_ADD, ys[s]);
          case (ccv)
            2'd0:    cond = m_cy;
            2'd1:    cond = m_z;
            2'd2:    cond = m_s;
            default: cond = m_p;
          endcase
          j = 14'(prog_ptr);
          emit({2'b01, sense, ccv, 3'b000});
          put_addr(j + 14'd8);
          emit(8'h3E);  // Fall-through marker
          emit({1'b0, idx});
          emit(8'h44);  // JMP past the taken marker
          put_addr(j + 14'd10);
          emit(8'h3E);
          emit({1'b1, idx});
          expect_write(HL_ADDR, {(sense == cond), idx});
        end
      end
    end
    emit(8'hFF);
    run_program(1'b0);
    compare_writes("jumps");
  endtask

  task automatic test_halt();
    clear_program();
    emit(8'h2E);
    emit(8'h20);
    emit(8'hFF);
    emit(8'h3E);  // Must never run
    emit(8'h99);
    run_program(1'b1);
    compare_writes("halt");
  endtask

  initial begin
    errors = 0;
    checks = 0;
    wait_errors = 0;
    rand_ready = 1'b0;
    test_reset_fetch();
    test_load_store();
    test_alu(1'b0);
    test_alu(1'b1);
    test_jumps();
    test_halt();
    errors = errors + wait_errors;
    $display("Checks: %0d  Errors: %0d  Wait errors: %0d", checks, errors, wait_errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
+incdir+tests
source/i8008_pkg.sv
source/ctrl_if.sv
source/reg_file.sv
source/alu.sv
source/program_counter.sv
source/datapath.sv
source/sequencer.sv
source/i8008_core.sv
tests/tb_i8008.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_i8008 -f src.f \
  --Mdir obj_dir -o tb_i8008_sim

./obj_dir/tb_i8008_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
